// File: hw/zet_pkg.sv
// zet package with ISA encodings, micro-instruction fields and shared word types
package zet_pkg;

  typedef logic [15:0] word_t;
  typedef logic [1:0]  reg_idx_t;
  typedef logic [4:0]  micro_addr_t;
  typedef logic [15:0] micro_ir_t;

  typedef enum logic [3:0] {
    NOP  = 4'd0,
    LDI  = 4'd1,
    ADDI = 4'd2,
    ADD  = 4'd3,
    SUB  = 4'd4,
    AND  = 4'd5,
    XOR  = 4'd6,
    LD   = 4'd7,
    ST   = 4'd8,
    JZ   = 4'd9,
    EI   = 4'd10,
    DI   = 4'd11,
    RETI = 4'd12,
    HLT  = 4'd13
  } opcode_t;

  // instruction word layout
  localparam int OPC_MSB = 15;
  localparam int OPC_LSB = 12;
  localparam int DST_MSB = 11;
  localparam int DST_LSB = 10;
  localparam int SRC_MSB = 9;
  localparam int SRC_LSB = 8;
  localparam int IMM_MSB = 7;
  localparam int IMM_LSB = 0;

  // micro-instruction fields, bits 15:13 spare
  localparam int UIR_ALU_LSB  = 0;
  localparam int UIR_ALU_MSB  = 2;
  localparam int UIR_BSEL_LSB = 3;
  localparam int UIR_BSEL_MSB = 4;
  localparam int UIR_REG_WE   = 5;
  localparam int UIR_MEM_RD   = 6;
  localparam int UIR_MEM_WR   = 7;
  localparam int UIR_JMP_Z    = 8;
  localparam int UIR_SET_IFL  = 9;
  localparam int UIR_CLR_IFL  = 10;
  localparam int UIR_RET_INT  = 11;
  localparam int UIR_END_SEQ  = 12;

  // alu operations
  localparam logic [2:0] ALU_PASS_B = 3'd0;
  localparam logic [2:0] ALU_ADD    = 3'd1;
  localparam logic [2:0] ALU_SUB    = 3'd2;
  localparam logic [2:0] ALU_AND    = 3'd3;
  localparam logic [2:0] ALU_XOR    = 3'd4;

  // second alu operand source
  localparam logic [1:0] BSEL_REG = 2'd0;
  localparam logic [1:0] BSEL_IMM = 2'd1;
  localparam logic [1:0] BSEL_MEM = 2'd2;

  localparam word_t INT_VECTOR = 16'h0010;
  localparam word_t RESET_IP   = 16'h0000;

  typedef enum logic [1:0] {FETCH, EXEC, INTACK} fetch_state_t;
  typedef enum logic {SEQ_IDLE, SEQ_STEP} seq_state_t;

endpackage

// File: hw/zet_fetch.sv
// zet fetch unit: instruction pointer, fetch FSM, instruction register and interrupt entry
module zet_fetch
  import zet_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     block_i,
  input  logic     end_seq_i,
  input  logic     intr_i,
  input  logic     ifl_i,
  input  logic     jmp_i,
  input  word_t    jmp_target_i,
  input  logic     ret_int_i,
  input  word_t    dat_i,
  output opcode_t  opcode_o,
  output reg_idx_t dst_o,
  output reg_idx_t src_o,
  output word_t    imm_o,
  output logic     exec_st_o,
  output logic     inta_o,
  output logic     clr_ifl_o,
  output word_t    pc_o
);

  fetch_state_t state_q;
  word_t        ip_q;
  word_t        ret_q;
  word_t        ir_q;
  word_t        end_ip;

  // decoded instruction fields
  assign opcode_o = opcode_t'(ir_q[OPC_MSB:OPC_LSB]);
  assign dst_o    = ir_q[DST_MSB:DST_LSB];
  assign src_o    = ir_q[SRC_MSB:SRC_LSB];
  assign imm_o    = {8'h00, ir_q[IMM_MSB:IMM_LSB]};

  assign exec_st_o = (state_q == EXEC);
  assign inta_o    = (state_q == INTACK) && !block_i;
  // interrupt entry masks further interrupts
  assign clr_ifl_o = inta_o;
  assign pc_o      = ip_q;

  // ip after the last micro step
  always_comb begin
    if (jmp_i) begin
      end_ip = jmp_target_i;
    end else if (ret_int_i) begin
      end_ip = ret_q;
    end else begin
      end_ip = ip_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FETCH;
      ip_q    <= RESET_IP;
    end else if (!block_i) begin
      case (state_q)
        FETCH: begin
          ip_q    <= ip_q + 16'd1;
          state_q <= EXEC;
        end
        EXEC: begin
          if (end_seq_i) begin
            ip_q    <= end_ip;
            // interrupts only at instruction boundaries
            state_q <= (intr_i && ifl_i) ? INTACK : FETCH;
          end
        end
        INTACK: begin
          ip_q    <= INT_VECTOR;
          state_q <= FETCH;
        end
        default: state_q <= FETCH;
      endcase
    end
  end

  // instruction word and saved return address
  always_ff @(posedge clk) begin
    if (!block_i && state_q == FETCH) begin
      ir_q <= dat_i;
    end
    if (!block_i && state_q == INTACK) begin
      ret_q <= ip_q;
    end
  end

endmodule

// File: hw/zet_decode.sv
// zet decode: microcode sequencer stepping through each opcode's micro sequence
module zet_decode
  import zet_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        block_i,
  input  logic        exec_st_i,
  input  opcode_t     opcode_i,
  output micro_addr_t seq_addr_o,
  output logic        end_seq_o
);

  seq_state_t state_q;
  logic       step_q;
  logic       last_step;

  // each opcode owns two rom slots, base at {opcode, 0}
  assign seq_addr_o = {opcode_i, step_q};

  // sequence length table, only memory ops need a second step
  always_comb begin
    case (opcode_i)
      LD:      last_step = 1'b1;
      ST:      last_step = 1'b1;
      default: last_step = 1'b0;
    endcase
  end

  assign end_seq_o = exec_st_i && (step_q == last_step);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= SEQ_IDLE;
      step_q  <= 1'b0;
    end else if (!block_i) begin
      case (state_q)
        SEQ_IDLE: begin
          // first step runs from idle, single-step ops finish here
          if (exec_st_i && !end_seq_o) begin
            state_q <= SEQ_STEP;
            step_q  <= step_q + 1'b1;
          end
        end
        SEQ_STEP: begin
          if (end_seq_o) begin
            state_q <= SEQ_IDLE;
            step_q  <= 1'b0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
          step_q  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: hw/zet_micro_data.sv
// zet micro data: microcode ROM plus the operand fields handed on to exec
module zet_micro_data
  import zet_pkg::*;
(
  input  micro_addr_t seq_addr_i,
  input  reg_idx_t    src_i,
  input  reg_idx_t    dst_i,
  input  word_t       imm_i,
  output micro_ir_t   micro_ir_o,
  output reg_idx_t    src_o,
  output reg_idx_t    dst_o,
  output word_t       imm_o
);

  logic [2:0] alu;
  logic [1:0] bsel;
  logic       reg_we;
  logic       mem_rd;
  logic       mem_wr;
  logic       jmp_z;
  logic       set_ifl;
  logic       clr_ifl;
  logic       ret_int;
  logic       last;

  always_comb begin
    alu     = ALU_PASS_B;
    bsel    = BSEL_REG;
    reg_we  = 1'b0;
    mem_rd  = 1'b0;
    mem_wr  = 1'b0;
    jmp_z   = 1'b0;
    set_ifl = 1'b0;
    clr_ifl = 1'b0;
    ret_int = 1'b0;
    last    = 1'b1;
    case (seq_addr_i)
      {LDI, 1'b0}: begin
        bsel   = BSEL_IMM;
        reg_we = 1'b1;
      end
      {ADDI, 1'b0}: begin
        alu    = ALU_ADD;
        bsel   = BSEL_IMM;
        reg_we = 1'b1;
      end
      {ADD, 1'b0}: begin
        alu    = ALU_ADD;
        reg_we = 1'b1;
      end
      {SUB, 1'b0}: begin
        alu    = ALU_SUB;
        reg_we = 1'b1;
      end
      {AND, 1'b0}: begin
        alu    = ALU_AND;
        reg_we = 1'b1;
      end
      {XOR, 1'b0}: begin
        alu    = ALU_XOR;
        reg_we = 1'b1;
      end
      // address step, exec latches src + imm
      {LD, 1'b0}: last = 1'b0;
      {LD, 1'b1}: begin
        bsel   = BSEL_MEM;
        reg_we = 1'b1;
        mem_rd = 1'b1;
      end
      {ST, 1'b0}: last = 1'b0;
      {ST, 1'b1}: mem_wr = 1'b1;
      {JZ, 1'b0}: jmp_z = 1'b1;
      {EI, 1'b0}: set_ifl = 1'b1;
      {DI, 1'b0}: clr_ifl = 1'b1;
      // return also re-enables interrupts
      {RETI, 1'b0}: begin
        ret_int = 1'b1;
        set_ifl = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    micro_ir_o                            = '0;
    micro_ir_o[UIR_ALU_MSB:UIR_ALU_LSB]   = alu;
    micro_ir_o[UIR_BSEL_MSB:UIR_BSEL_LSB] = bsel;
    micro_ir_o[UIR_REG_WE]                = reg_we;
    micro_ir_o[UIR_MEM_RD]                = mem_rd;
    micro_ir_o[UIR_MEM_WR]                = mem_wr;
    micro_ir_o[UIR_JMP_Z]                 = jmp_z;
    micro_ir_o[UIR_SET_IFL]               = set_ifl;
    micro_ir_o[UIR_CLR_IFL]               = clr_ifl;
    micro_ir_o[UIR_RET_INT]               = ret_int;
    micro_ir_o[UIR_END_SEQ]               = last;
  end

  assign src_o = src_i;
  assign dst_o = dst_i;
  assign imm_o = imm_i;

endmodule

// File: hw/zet_exec.sv
// zet exec unit: register file, ALU, flags and data-side memory access
module zet_exec
  import zet_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      block_i,
  input  logic      exec_st_i,
  input  micro_ir_t micro_ir_i,
  input  reg_idx_t  src_i,
  input  reg_idx_t  dst_i,
  input  word_t     imm_i,
  input  word_t     mem_dat_i,
  input  logic      clr_ifl_i,
  output word_t     addr_o,
  output word_t     wr_dat_o,
  output logic      we_o,
  output logic      mem_rd_o,
  output logic      zf_o,
  output logic      ifl_o,
  output logic      jmp_o,
  output word_t     jmp_target_o
);

  word_t      regs_q [4];
  word_t      addr_q;
  word_t      a_val;
  word_t      b_val;
  word_t      alu_res;
  logic       zf_q;
  logic       ifl_q;
  logic       step;
  logic [2:0] alu_op;
  logic [1:0] b_sel;
  logic       reg_we;
  logic       mem_rd;
  logic       mem_wr;
  logic       jmp_z;
  logic       set_ifl;
  logic       clr_ifl;

  // micro word fields
  assign alu_op  = micro_ir_i[UIR_ALU_MSB:UIR_ALU_LSB];
  assign b_sel   = micro_ir_i[UIR_BSEL_MSB:UIR_BSEL_LSB];
  assign reg_we  = micro_ir_i[UIR_REG_WE];
  assign mem_rd  = micro_ir_i[UIR_MEM_RD];
  assign mem_wr  = micro_ir_i[UIR_MEM_WR];
  assign jmp_z   = micro_ir_i[UIR_JMP_Z];
  assign set_ifl = micro_ir_i[UIR_SET_IFL];
  assign clr_ifl = micro_ir_i[UIR_CLR_IFL];

  // a micro step commits only when not stalled
  assign step  = exec_st_i && !block_i;
  assign a_val = regs_q[dst_i];

  always_comb begin
    case (b_sel)
      BSEL_IMM: b_val = imm_i;
      BSEL_MEM: b_val = mem_dat_i;
      default:  b_val = regs_q[src_i];
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_ADD: alu_res = a_val + b_val;
      ALU_SUB: alu_res = a_val - b_val;
      ALU_AND: alu_res = a_val & b_val;
      ALU_XOR: alu_res = a_val ^ b_val;
      default: alu_res = b_val;
    endcase
  end

  assign addr_o       = addr_q;
  // stores write the dst register
  assign wr_dat_o     = a_val;
  assign we_o         = step && mem_wr;
  assign mem_rd_o     = exec_st_i && mem_rd;
  assign zf_o         = zf_q;
  assign ifl_o        = ifl_q;
  assign jmp_o        = exec_st_i && jmp_z && zf_q;
  assign jmp_target_o = imm_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        regs_q[i] <= '0;
      end
      addr_q <= '0;
      zf_q   <= 1'b0;
      ifl_q  <= 1'b0;
    end else begin
      if (step && reg_we) begin
        regs_q[dst_i] <= alu_res;
        zf_q          <= (alu_res == '0);
      end
      // non-memory steps latch the effective address for the next step
      if (step && !mem_rd && !mem_wr) begin
        addr_q <= regs_q[src_i] + imm_i;
      end
      if (clr_ifl_i) begin
        ifl_q <= 1'b0;
      end else if (step && set_ifl) begin
        ifl_q <= 1'b1;
      end else if (step && clr_ifl) begin
        ifl_q <= 1'b0;
      end
    end
  end

endmodule

// File: hw/zet_core.sv
// zet core top: fetch/exec bus multiplexing and halt wake-up on interrupts
module zet_core
  import zet_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  intr_i,
  output logic  inta_o,
  output word_t cpu_adr_o,
  input  word_t cpu_dat_i,
  output word_t cpu_dat_o,
  output logic  cpu_we_o,
  input  logic  cpu_block_i,
  output logic  cpu_mem_op_o,
  output word_t pc_o
);

  opcode_t     opcode;
  reg_idx_t    f_dst;
  reg_idx_t    f_src;
  reg_idx_t    m_dst;
  reg_idx_t    m_src;
  word_t       f_imm;
  word_t       m_imm;
  word_t       exec_addr;
  word_t       jmp_target;
  micro_addr_t seq_addr;
  micro_ir_t   micro_ir;
  logic        exec_st;
  logic        end_seq;
  logic        ifl;
  logic        jmp;
  logic        clr_ifl;
  logic        mem_rd;
  logic        ret_int;
  logic        block;
  logic        hlt_op;
  logic        hlt_in;
  logic        hlt_out;
  logic        hlt_op_q;
  logic        hlt_q;

  zet_fetch fetch (
    .clk          (clk),
    .rst          (rst),
    .block_i      (block),
    .end_seq_i    (end_seq),
    .intr_i       (intr_i),
    .ifl_i        (ifl),
    .jmp_i        (jmp),
    .jmp_target_i (jmp_target),
    .ret_int_i    (ret_int),
    .dat_i        (cpu_dat_i),
    .opcode_o     (opcode),
    .dst_o        (f_dst),
    .src_o        (f_src),
    .imm_o        (f_imm),
    .exec_st_o    (exec_st),
    .inta_o       (inta_o),
    .clr_ifl_o    (clr_ifl),
    .pc_o         (pc_o)
  );

  zet_decode decode (
    .clk        (clk),
    .rst        (rst),
    .block_i    (block),
    .exec_st_i  (exec_st),
    .opcode_i   (opcode),
    .seq_addr_o (seq_addr),
    .end_seq_o  (end_seq)
  );

  zet_micro_data micro_data (
    .seq_addr_i (seq_addr),
    .src_i      (f_src),
    .dst_i      (f_dst),
    .imm_i      (f_imm),
    .micro_ir_o (micro_ir),
    .src_o      (m_src),
    .dst_o      (m_dst),
    .imm_o      (m_imm)
  );

  zet_exec exec (
    .clk          (clk),
    .rst          (rst),
    .block_i      (block),
    .exec_st_i    (exec_st),
    .micro_ir_i   (micro_ir),
    .src_i        (m_src),
    .dst_i        (m_dst),
    .imm_i        (m_imm),
    .mem_dat_i    (cpu_dat_i),
    .clr_ifl_i    (clr_ifl),
    .addr_o       (exec_addr),
    .wr_dat_o     (cpu_dat_o),
    .we_o         (cpu_we_o),
    .mem_rd_o     (mem_rd),
    .zf_o         (),
    .ifl_o        (ifl),
    .jmp_o        (jmp),
    .jmp_target_o (jmp_target)
  );

  assign ret_int   = exec_st && micro_ir[UIR_RET_INT];
  assign cpu_adr_o = exec_st ? exec_addr : pc_o;
  // outside exec every unacknowledged cycle is a fetch
  assign cpu_mem_op_o = exec_st ? (mem_rd || micro_ir[UIR_MEM_WR]) : !inta_o;

  // halt entry on the first cycle of a HLT step
  assign hlt_op  = exec_st && (opcode == HLT);
  assign hlt_out = intr_i && ifl;
  assign hlt_in  = hlt_op && !hlt_op_q && !hlt_out;
  assign block   = cpu_block_i || hlt_q || hlt_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      hlt_op_q <= 1'b0;
      hlt_q    <= 1'b0;
    end else begin
      hlt_op_q <= hlt_op;
      if (hlt_in) begin
        hlt_q <= 1'b1;
      end else if (hlt_out) begin
        hlt_q <= 1'b0;
      end
    end
  end

endmodule

// File: dv/zet_isa_model.svh
// zet instruction-level reference model, replays the program with the observed interrupt points
`ifndef ZET_ISA_MODEL_SVH
`define ZET_ISA_MODEL_SVH

task automatic run_model();
  word_t   r [4];
  word_t   ip;
  word_t   ret;
  word_t   ir;
  word_t   imm;
  word_t   res;
  word_t   ea;
  logic    zf;
  logic    ifl;
  logic    wr;
  logic    wait_int;
  opcode_t op;
  reg_idx_t d;
  reg_idx_t s;
  ip       = RESET_IP;
  ret      = '0;
  zf       = 1'b0;
  ifl      = 1'b0;
  wait_int = 1'b0;
  for (int i = 0; i < 4; i++) begin
    r[i] = '0;
  end
  while (ip != word_t'(END_ADDR)) begin
    if (int_ret.size() != 0 && int_ret[0] == ip) begin
      if (!ifl) begin
        $display("interrupt acknowledged while interrupts were disabled");
        stop_on_failure();
      end
      void'(int_ret.pop_front());
      // interrupt entry at this boundary
      ret      = ip;
      ifl      = 1'b0;
      ip       = INT_VECTOR;
      wait_int = 1'b0;
    end else if (wait_int) begin
      $display("HLT resumed without an interrupt at address %h", ip);
      stop_on_failure();
    end else begin
      ir  = model_mem[ip];
      ip  = ip + 16'd1;
      op  = opcode_t'(ir[15:12]);
      d   = ir[11:10];
      s   = ir[9:8];
      imm = {8'h00, ir[7:0]};
      wr  = 1'b1;
      res = '0;
      case (op)
        LDI:  res = imm;
        ADDI: res = r[d] + imm;
        ADD:  res = r[d] + r[s];
        SUB:  res = r[d] - r[s];
        AND:  res = r[d] & r[s];
        XOR:  res = r[d] ^ r[s];
        LD:   res = model_mem[r[s] + imm];
        ST: begin
          ea            = r[s] + imm;
          model_mem[ea] = r[d];
          exp_adr.push_back(ea);
          exp_dat.push_back(r[d]);
          wr = 1'b0;
        end
        default: begin
          wr = 1'b0;
          if (op == JZ && zf) ip = imm;
          if (op == EI) ifl = 1'b1;
          if (op == DI) ifl = 1'b0;
          if (op == HLT) wait_int = 1'b1;
          if (op == RETI) begin
            ip  = ret;
            ifl = 1'b1;
          end
        end
      endcase
      if (wr) begin
        r[d] = res;
        zf   = (res == 16'h0000);
      end
    end
  end
endtask

`endif

// File: dv/zet_core_tb.sv
// zet core testbench: random program, memory model, interrupt stimulus and store checking
module zet_core_tb
  import zet_pkg::*;
();

  localparam int MAIN_BASE  = 32;
  localparam int END_BASE   = 144;
  localparam int END_ADDR   = 151;
  localparam int MAIN_LEN   = END_BASE - MAIN_BASE;
  // up to three cycles per instruction, stretched by random block
  localparam int MAX_CYCLES = (MAIN_LEN + 32) * 3 * 4 + 4000;

  logic  clk;
  logic  rst;
  logic  intr_i;
  logic  inta_o;
  word_t cpu_adr_o;
  word_t cpu_dat_i;
  word_t cpu_dat_o;
  logic  cpu_we_o;
  logic  cpu_block_i;
  logic  cpu_mem_op_o;
  word_t pc_o;

  word_t       mem [65536];
  word_t       model_mem [65536];
  word_t       act_adr [$];
  word_t       act_dat [$];
  word_t       exp_adr [$];
  word_t       exp_dat [$];
  word_t       int_ret [$];
  logic [31:0] lcg_state;

  zet_core UUT (
    .clk          (clk),
    .rst          (rst),
    .intr_i       (intr_i),
    .inta_o       (inta_o),
    .cpu_adr_o    (cpu_adr_o),
    .cpu_dat_i    (cpu_dat_i),
    .cpu_dat_o    (cpu_dat_o),
    .cpu_we_o     (cpu_we_o),
    .cpu_block_i  (cpu_block_i),
    .cpu_mem_op_o (cpu_mem_op_o),
    .pc_o         (pc_o)
  );

  // combinational read, write on the clock edge
  assign cpu_dat_i = mem[cpu_adr_o];

  always @(posedge clk) begin
    if (!rst && cpu_we_o) begin
      mem[cpu_adr_o] = cpu_dat_o;
    end
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_equal(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[30:15]} % n;
  endfunction

  function automatic word_t enc(opcode_t op, reg_idx_t d, reg_idx_t s, logic [7:0] imm);
    return {op, d, s, imm};
  endfunction

  `include "zet_isa_model.svh"

  task automatic build_image();
    int         k;
    int         a;
    int         tgt;
    word_t      w;
    reg_idx_t   d;
    reg_idx_t   s;
    logic [7:0] imm;
    for (k = 0; k < 65536; k++) begin
      w = word_t'(k);
      mem[w] = {w[7:0], w[15:8]} ^ 16'hc3a5;
    end
    for (k = 0; k < 256; k++) begin
      mem[16'h8000 + word_t'(k)] = word_t'(rand_below(65536));
    end
    // prologue builds r0 = 0x8000 as data base, then jumps past the handler
    mem[0] = enc(LDI, 2'd0, 2'd0, 8'h80);
    for (k = 1; k <= 8; k++) begin
      mem[word_t'(k)] = enc(ADD, 2'd0, 2'd0, 8'h00);
    end
    mem[9]  = enc(XOR, 2'd1, 2'd1, 8'h00);
    mem[10] = enc(JZ, 2'd0, 2'd0, 8'(MAIN_BASE));
    for (k = 11; k < 16; k++) begin
      mem[word_t'(k)] = enc(NOP, 2'd0, 2'd0, 8'h00);
    end
    mem[INT_VECTOR]         = enc(ST, 2'd2, 2'd0, 8'hf8);
    mem[INT_VECTOR + 16'd1] = enc(RETI, 2'd0, 2'd0, 8'h00);
    a = MAIN_BASE;
    while (a < END_BASE) begin
      d   = 2'(rand_below(3) + 1);
      s   = 2'(rand_below(4));
      imm = 8'(rand_below(256));
      case (rand_below(15))
        0:       mem[word_t'(a)] = enc(LDI, d, s, imm);
        1:       mem[word_t'(a)] = enc(ADDI, d, s, imm);
        2:       mem[word_t'(a)] = enc(ADD, d, s, imm);
        3:       mem[word_t'(a)] = enc(SUB, d, s, imm);
        4:       mem[word_t'(a)] = enc(AND, d, s, imm);
        5:       mem[word_t'(a)] = enc(XOR, d, s, imm);
        6, 7:    mem[word_t'(a)] = enc(LD, d, 2'd0, imm);
        8, 9:    mem[word_t'(a)] = enc(ST, s, 2'd0, imm);
        10: begin
          tgt = a + 2 + int'(rand_below(4));
          if (tgt > END_BASE) tgt = END_BASE;
          mem[word_t'(a)] = enc(JZ, 2'd0, 2'd0, 8'(tgt));
        end
        11:      mem[word_t'(a)] = enc(EI, 2'd0, 2'd0, 8'h00);
        12:      mem[word_t'(a)] = enc(DI, 2'd0, 2'd0, 8'h00);
        13: begin
          // halt only with interrupts enabled
          if (a + 1 < END_BASE) begin
            mem[word_t'(a)]     = enc(EI, 2'd0, 2'd0, 8'h00);
            mem[word_t'(a + 1)] = enc(HLT, 2'd0, 2'd0, 8'h00);
            a++;
          end else begin
            mem[word_t'(a)] = enc(NOP, 2'd0, 2'd0, 8'h00);
          end
        end
        default: mem[word_t'(a)] = enc(NOP, 2'd0, 2'd0, 8'h00);
      endcase
      a++;
    end
    // a jump never lands on HLT, only on the EI in front of it
    for (a = MAIN_BASE; a < END_BASE; a++) begin
      if (mem[word_t'(a)][15:12] == JZ) begin
        tgt = int'(mem[word_t'(a)][7:0]);
        if (mem[word_t'(tgt)][15:12] == HLT) begin
          mem[word_t'(a)][7:0] = 8'(tgt - 1);
        end
      end
    end
    // tail disables interrupts, dumps all registers and spins
    mem[word_t'(END_BASE)]     = enc(DI, 2'd0, 2'd0, 8'h00);
    mem[word_t'(END_BASE + 1)] = enc(DI, 2'd0, 2'd0, 8'h00);
    for (k = 0; k < 4; k++) begin
      mem[word_t'(END_BASE + 2 + k)] = enc(ST, 2'(k), 2'd0, 8'(252 + k));
    end
    mem[word_t'(END_BASE + 6)] = enc(XOR, 2'd1, 2'd1, 8'h00);
    mem[word_t'(END_ADDR)]     = enc(JZ, 2'd0, 2'd0, 8'(END_ADDR));
    for (k = 0; k < 65536; k++) begin
      model_mem[word_t'(k)] = mem[word_t'(k)];
    end
  endtask

  initial begin
    int   cycles;
    int   settle;
    logic ack_seen;
    logic halted;
    rst         = 1'b1;
    intr_i      = 1'b0;
    cpu_block_i = 1'b0;
    lcg_state   = 32'd57;
    cycles      = 0;
    settle      = 0;
    ack_seen    = 1'b0;
    halted      = 1'b0;
    build_image();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (settle < 24) begin
      @(negedge clk);
      cpu_block_i = (rand_below(4) == 0);
      // intr held until acknowledged, raised only while the main program runs
      if (ack_seen) begin
        intr_i   = 1'b0;
        ack_seen = 1'b0;
      end else if (!intr_i && pc_o >= word_t'(MAIN_BASE) && pc_o <= word_t'(END_BASE) &&
                   rand_below(16) == 0) begin
        intr_i = 1'b1;
      end
      #1;
      if (cpu_we_o) begin
        if (cpu_block_i) begin
          $display("memory write while the core was blocked");
          stop_on_failure();
        end
        check_equal("memory op strobe on write", 16'h0001, word_t'(cpu_mem_op_o));
        act_adr.push_back(cpu_adr_o);
        act_dat.push_back(cpu_dat_o);
      end
      // program fetches sit below the data region
      if (cpu_mem_op_o && !cpu_we_o && !cpu_block_i && cpu_adr_o < 16'h8000 &&
          cpu_dat_i[15:12] == HLT) begin
        halted = 1'b1;
      end else if (halted && !intr_i && cpu_mem_op_o) begin
        $display("bus access after HLT before any interrupt, pc %h", pc_o);
        stop_on_failure();
      end
      if (inta_o) begin
        if (!intr_i) begin
          $display("inta pulse without a pending interrupt");
          stop_on_failure();
        end
        int_ret.push_back(pc_o);
        ack_seen = 1'b1;
        halted   = 1'b0;
      end
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("timeout after %0d cycles, pc %h", cycles, pc_o);
        stop_on_failure();
      end
      if (pc_o >= word_t'(END_ADDR)) begin
        settle++;
      end else begin
        settle = 0;
      end
    end
    run_model();
    check_equal("pending interrupts left", 16'h0000, word_t'(int_ret.size()));
    check_equal("write count", word_t'(exp_adr.size()), word_t'(act_adr.size()));
    for (int i = 0; i < exp_adr.size(); i++) begin
      check_equal($sformatf("write %0d address", i), exp_adr[i], act_adr[i]);
      check_equal($sformatf("write %0d data", i), exp_dat[i], act_dat[i]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: list.f
+incdir+dv
hw/zet_pkg.sv
hw/zet_fetch.sv
hw/zet_decode.sv
hw/zet_micro_data.sv
hw/zet_exec.sv
hw/zet_core.sv
dv/zet_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the zet core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module zet_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vzet_core_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
